// ==== sim/tbModel.svh ====
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

	// -------------------- random operands
	logic [31:0] lfsrState = 32'habb4c6bb;

	// fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int n = 0; n < count; n++)
		begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic logic [tileElems*dataWidth-1:0] randomTile();
		logic [tileElems*dataWidth-1:0] tile;
		for (int n = 0; n < tileElems; n++)
			tile[n*dataWidth +: dataWidth] = dataWidth'(randomBits(dataWidth));
		return tile;
	endfunction

	// -------------------- models
	function automatic logic [tileElems*accWidth-1:0] tileProduct(
		input logic [tileElems*dataWidth-1:0] a, input logic [tileElems*dataWidth-1:0] b);
		logic [tileElems*accWidth-1:0] prod;
		int acc;
		for (int i = 0; i < tileDim; i++)
		begin
			for (int j = 0; j < tileDim; j++)
			begin
				acc = 0;
				for (int k = 0; k < tileDim; k++)
					acc += int'($signed(a[(i*tileDim+k)*dataWidth +: dataWidth]))
						* int'($signed(b[(k*tileDim+j)*dataWidth +: dataWidth]));
				prod[(i*tileDim+j)*accWidth +: accWidth] = accWidth'(acc);
			end
		end
		return prod;
	endfunction

	function automatic int tileImportance(input logic [tileElems*accWidth-1:0] res);
		int v;
		int sum;
		sum = 0;
		for (int n = 0; n < tileElems; n++)
		begin
			v = $signed(res[n*accWidth +: accWidth]);
			sum += (v < 0) ? -v : v;   // magnitude
		end
		return sum;
	endfunction

	// keep tiles at or above min + (max - min) * ratio / 8
	function automatic logic [tilesPerRow-1:0] maskModel(input int imp [tilesPerRow],
		input int count, input int ratio);
		int minV;
		int maxV;
		int thr;
		logic [tilesPerRow-1:0] bits;
		minV = imp[0];
		maxV = imp[0];
		for (int n = 1; n < count; n++)
		begin
			minV = (imp[n] < minV) ? imp[n] : minV;
			maxV = (imp[n] > maxV) ? imp[n] : maxV;
		end
		thr = minV + (((maxV - minV) * ratio) >> ratioShift);
		bits = '0;
		for (int n = 0; n < count; n++)
			bits[n] = (imp[n] >= thr);
		return bits;
	endfunction

	function automatic logic headDecision(input logic [headSumWidth-1:0] sum,
		input logic [headSumWidth-1:0] thr);
		return sum <= thr;
	endfunction

	// -------------------- compare tasks
	task automatic checkResult(input logic [tileElems*accWidth-1:0] got,
		input logic [tileElems*accWidth-1:0] expected, input string what);
		if (got !== expected)
		begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, expected);
			abortRun();
		end
	endtask

	task automatic checkMask(input logic [tilesPerRow-1:0] got,
		input logic [tilesPerRow-1:0] expected, input string what);
		if (got !== expected)
		begin
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, expected);
			abortRun();
		end
	endtask

	task automatic checkFlag(input logic got, input logic expected, input string what);
		if (got !== expected)
		begin
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, expected);
			abortRun();
		end
	endtask

`endif

// ==== sim/tbAttentionPruner.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbAttentionPruner import attnPkg::*;
();

	logic clk;
	logic _resetRow;
	logic tileValid;
	logic endOfRow;
	logic endOfHead;
	logic [tileElems*dataWidth-1:0] aTile;
	logic [tileElems*dataWidth-1:0] bTile;
	logic [ratioWidth-1:0] blockPruningRatio;
	logic [headSumWidth-1:0] headThreshold;
	wire resultValid;
	wire [tileElems*accWidth-1:0] result;
	wire maskValid;
	wire [tilesPerRow-1:0] mask;
	wire headValid;
	wire pruneHead;

	logic [tileElems*dataWidth-1:0] rowA [tilesPerRow];
	logic [tileElems*dataWidth-1:0] rowB [tilesPerRow];
	int rowImp [tilesPerRow];
	logic [headSumWidth-1:0] headAccum;   // head sum the DUT should be holding

	attentionPruner dut (
		.clk(clk), ._resetRow(_resetRow), .tileValid(tileValid), .endOfRow(endOfRow),
		.endOfHead(endOfHead), .aTile(aTile), .bTile(bTile),
		.blockPruningRatio(blockPruningRatio), .headThreshold(headThreshold),
		.resultValid(resultValid), .result(result), .maskValid(maskValid), .mask(mask),
		.headValid(headValid), .pruneHead(pruneHead)
	);

	initial
		clk = 1'b0;
	always #10 clk = ~clk;   // 20 ns period

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

`include "tbModel.svh"

	// -------------------- drive helpers
	function automatic logic strobeLevel(input int which);
		case (which)
			0: return resultValid;
			1: return maskValid;
			default: return headValid;
		endcase
	endfunction

	// counts edges from the sampling edge until the strobe shows up
	task automatic waitStrobe(input int which, input string name, input int startEdges,
		input int expectEdges);
		int edges;
		logic seen;
		edges = startEdges;
		seen = 1'b0;
		while (!seen && edges < 40)
		begin
			@(posedge clk);
			#1;
			edges++;
			seen = strobeLevel(which);
		end
		if (!seen)
		begin
			$display("timeout: %s never went high", name);
			abortRun();
		end
		else if (edges != expectEdges)
		begin
			$display("FAIL %0t: %s came %0d edges after sampling, expected %0d", $time,
				name, edges, expectEdges);
			abortRun();
		end
	endtask

	task automatic driveTile(input logic [tileElems*dataWidth-1:0] a,
		input logic [tileElems*dataWidth-1:0] b, input logic eor, input logic eoh);
		tileValid = 1'b1;
		aTile = a;
		bTile = b;
		endOfRow = eor;
		endOfHead = eoh;
		@(posedge clk);
		#1;
	endtask

	task automatic idleInputs();
		tileValid = 1'b0;
		endOfRow = 1'b0;
		endOfHead = 1'b0;
	endtask

	task automatic applyReset();
		idleInputs();
		_resetRow = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		_resetRow = 1'b1;
		headAccum = '0;
	endtask

	task automatic genRow(input int count, output int rowSum);
		rowSum = 0;
		for (int t = 0; t < count; t++)
		begin
			rowA[t] = randomTile();
			rowB[t] = randomTile();
			rowImp[t] = tileImportance(tileProduct(rowA[t], rowB[t]));
			rowSum += rowImp[t];
		end
	endtask

	// sends a generated row, then checks the head decision and the mask
	task automatic playRow(input int count, input int ratio, input logic eoh,
		input logic expPrune);
		logic [tilesPerRow-1:0] expMask;
		expMask = maskModel(rowImp, count, ratio);
		blockPruningRatio = ratioWidth'(ratio);
		for (int t = 0; t < count; t++)
			driveTile(rowA[t], rowB[t], t == count - 1, eoh && (t == count - 1));
		idleInputs();
		for (int t = 0; t < count; t++)
			headAccum += headSumWidth'(rowImp[t]);
		if (eoh)
		begin
			waitStrobe(2, "headValid", 1, 3);
			checkFlag(pruneHead, expPrune, "pruneHead");
			headAccum = '0;
			waitStrobe(1, "maskValid", 3, 4);
		end
		else
			waitStrobe(1, "maskValid", 1, 4);
		checkMask(mask, expMask, "row mask");
	endtask

	// -------------------- tests
	task automatic testResetState();
		checkFlag(resultValid, 1'b0, "resultValid after reset");
		checkFlag(maskValid, 1'b0, "maskValid after reset");
		checkFlag(headValid, 1'b0, "headValid after reset");
		checkFlag(pruneHead, 1'b0, "pruneHead after reset");
		checkMask(mask, '0, "mask after reset");
	endtask

	task automatic testSingleTile();
		logic [tileElems*dataWidth-1:0] a;
		logic [tileElems*dataWidth-1:0] b;
		a = randomTile();
		b = randomTile();
		driveTile(a, b, 1'b0, 1'b0);
		idleInputs();
		waitStrobe(0, "resultValid", 1, 2);
		checkResult(result, tileProduct(a, b), "single tile");
	endtask

	task automatic testStreamedTiles();
		int sum;
		genRow(8, sum);
		fork
			begin
				for (int t = 0; t < 8; t++)
					driveTile(rowA[t], rowB[t], 1'b0, 1'b0);
				idleInputs();
			end
			begin
				waitStrobe(0, "resultValid", 0, 2);
				for (int t = 0; t < 8; t++)
				begin
					if (t > 0)
					begin
						@(posedge clk);
						#1;
					end
					checkFlag(resultValid, 1'b1, "streamed resultValid");
					checkResult(result, tileProduct(rowA[t], rowB[t]), "streamed tile");
				end
			end
		join
	endtask

	task automatic testRowMask();
		int sum;
		applyReset();   // the tile tests left an open row behind
		genRow(16, sum);
		playRow(16, 0, 1'b0, 1'b0);
		genRow(16, sum);
		playRow(16, 4, 1'b0, 1'b0);
		genRow(16, sum);
		playRow(16, 7, 1'b0, 1'b0);
		genRow(5, sum);
		playRow(5, 4, 1'b0, 1'b0);   // short row so the upper bits stay 0
	endtask

	task automatic testHeadPruning();
		int sum;
		for (int round = 0; round < 2; round++)
		begin
			genRow(6, sum);
			playRow(6, 4, 1'b0, 1'b0);
			genRow(7, sum);
			headThreshold = headAccum + headSumWidth'(sum) - headSumWidth'(round);
			playRow(7, 2, 1'b1, headDecision(headAccum + headSumWidth'(sum), headThreshold));
		end
	endtask

	task automatic testResetMidRow();
		int sum;
		genRow(5, sum);
		playRow(5, 3, 1'b0, 1'b0);   // leaves a nonzero head sum
		genRow(3, sum);
		for (int t = 0; t < 3; t++)
			driveTile(rowA[t], rowB[t], 1'b0, 1'b0);
		applyReset();
		genRow(6, sum);
		headThreshold = headSumWidth'(sum);
		playRow(6, 5, 1'b1, headDecision(headAccum + headSumWidth'(sum), headThreshold));
	endtask

	// -------------------- main sequence
	initial
	begin
		headAccum = '0;
		aTile = '0;
		bTile = '0;
		blockPruningRatio = '0;
		headThreshold = '0;
		applyReset();
		testResetState();
		testSingleTile();
		testStreamedTiles();
		testRowMask();
		testHeadPruning();
		testResetMidRow();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
verilog/attnPkg.sv
verilog/tileBus.sv
verilog/scoreBus.sv
verilog/rowStatsBus.sv
verilog/tileDecode.sv
verilog/tileMultiply.sv
verilog/rowImportance.sv
verilog/blockMask.sv
verilog/attentionPruner.sv
sim/tbAttentionPruner.sv

// ==== verilog/attentionPruner.sv ====
`timescale 1ns/1ps
`default_nettype none

module attentionPruner import attnPkg::*;
(
	input wire clk,
	input wire _resetRow,
	input wire tileValid,
	input wire endOfRow,
	input wire endOfHead,
	input wire [tileElems*dataWidth-1:0] aTile,
	input wire [tileElems*dataWidth-1:0] bTile,
	input wire [ratioWidth-1:0] blockPruningRatio,
	input wire [headSumWidth-1:0] headThreshold,
	output wire resultValid,
	output wire [tileElems*accWidth-1:0] result,
	output wire maskValid,
	output wire [tilesPerRow-1:0] mask,
	output wire headValid,
	output wire pruneHead
);

	// -------------------- stage links
	tileBus tiles ();
	scoreBus scores ();
	rowStatsBus stats ();

	// decode, registers the flat operands
	tileDecode decode (
		.clk(clk),
		._resetRow(_resetRow),
		.tileValid(tileValid),
		.endOfRow(endOfRow),
		.endOfHead(endOfHead),
		.aTile(aTile),
		.bTile(bTile),
		.tiles(tiles.source)
	);

	// execute, product and importance
	tileMultiply execute (
		.clk(clk),
		._resetRow(_resetRow),
		.tiles(tiles.sink),
		.scores(scores.source),
		.resultValid(resultValid),
		.result(result)
	);

	// -------------------- result side
	rowImportance rowScore (
		.clk(clk),
		._resetRow(_resetRow),
		.headThreshold(headThreshold),
		.scores(scores.sink),
		.stats(stats.source),
		.headValid(headValid),
		.pruneHead(pruneHead)
	);

	blockMask maskGen (
		.clk(clk),
		._resetRow(_resetRow),
		.blockPruningRatio(blockPruningRatio),
		.stats(stats.sink),
		.maskValid(maskValid),
		.mask(mask)
	);

endmodule

`default_nettype wire

// ==== verilog/attnPkg.sv ====
`default_nettype none

package attnPkg;

	// -------------------- operand and result widths
	localparam int dataWidth = 8;          // signed A or B element
	localparam int tileDim = 4;            // tile side
	localparam int tileElems = 16;         // elements per tile
	localparam int accWidth = 18;          // 16-bit product plus growth over four terms
	localparam int importanceWidth = 22;   // sum of 16 magnitudes

	// -------------------- row and head bookkeeping
	localparam int headSumWidth = 32;      // row sum and head sum
	localparam int tilesPerRow = 16;       // score slots per row, also the mask width
	localparam int tileIndexWidth = 5;     // counts 0 to tilesPerRow

	// pruning ratio is given in eighths
	localparam int ratioWidth = 3;
	localparam int ratioShift = 3;

endpackage

`default_nettype wire

// ==== verilog/blockMask.sv ====
`timescale 1ns/1ps
`default_nettype none

module blockMask import attnPkg::*;
(
	input wire clk,
	input wire _resetRow,
	input wire [ratioWidth-1:0] blockPruningRatio,
	rowStatsBus.sink stats,
	output logic maskValid,
	output logic [tilesPerRow-1:0] mask
);

	logic [importanceWidth-1:0] spread;
	logic [importanceWidth+ratioWidth-1:0] scaled;
	logic [importanceWidth-1:0] threshold;
	logic [tilesPerRow-1:0] keep;

	// -------------------- threshold
	// min + (max - min) * ratio / 8, never above rowMax
	assign spread = stats.rowMax - stats.rowMin;
	assign scaled = spread * blockPruningRatio;
	assign threshold = stats.rowMin + importanceWidth'(scaled >> ratioShift);

	always_comb
	begin
		for (int n = 0; n < tilesPerRow; n++)
			keep[n] = (n < stats.tileCount) && (stats.scores[n] >= threshold);
	end

	// -------------------- mask register
	always_ff @(posedge clk or negedge _resetRow)
	begin
		if (!_resetRow)
		begin
			maskValid <= 1'b0;
			mask <= '0;
		end
		else
		begin
			maskValid <= stats.rowDone;
			if (stats.rowDone)   // held until the next row ends
				mask <= keep;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rowImportance.sv ====
`timescale 1ns/1ps
`default_nettype none

module rowImportance import attnPkg::*;
(
	input wire clk,
	input wire _resetRow,
	input wire [headSumWidth-1:0] headThreshold,
	scoreBus.sink scores,
	rowStatsBus.source stats,
	output logic headValid,
	output logic pruneHead
);

	logic [importanceWidth-1:0] scoreMem [tilesPerRow];
	logic [tileIndexWidth-1:0] tileCount;
	logic [importanceWidth-1:0] runMin;
	logic [importanceWidth-1:0] runMax;
	logic [headSumWidth-1:0] rowSum;
	logic [headSumWidth-1:0] headSum;
	logic slotFree;
	logic [tileIndexWidth-1:0] nextCount;
	logic [importanceWidth-1:0] nextMin;
	logic [importanceWidth-1:0] nextMax;
	logic [headSumWidth-1:0] nextRowSum;
	logic [headSumWidth-1:0] nextHeadSum;

	// -------------------- row state including the incoming tile
	assign slotFree = tileCount < tilesPerRow;
	assign nextCount = slotFree ? tileCount + 1'b1 : tileCount;   // tiles past 16 unscored
	assign nextMin = (scores.importance < runMin) ? scores.importance : runMin;
	assign nextMax = (scores.importance > runMax) ? scores.importance : runMax;
	assign nextRowSum = rowSum + headSumWidth'(scores.importance);
	assign nextHeadSum = headSum + nextRowSum;

	// slots above tileCount are stale, blockMask masks them off
	assign stats.scores = scoreMem;

	always_ff @(posedge clk)
	begin
		if (scores.valid && slotFree)
			scoreMem[tileCount[tileIndexWidth-2:0]] <= scores.importance;
	end

	// -------------------- row and head bookkeeping
	always_ff @(posedge clk or negedge _resetRow)
	begin
		if (!_resetRow)
		begin
			tileCount <= '0;
			runMin <= '1;
			runMax <= '0;
			rowSum <= '0;
			headSum <= '0;
			stats.rowDone <= 1'b0;
			stats.rowMin <= '0;
			stats.rowMax <= '0;
			stats.tileCount <= '0;
			headValid <= 1'b0;
			pruneHead <= 1'b0;
		end
		else
		begin
			stats.rowDone <= 1'b0;
			headValid <= 1'b0;
			if (scores.valid && scores.endOfRow)
			begin
				stats.rowDone <= 1'b1;
				stats.rowMin <= nextMin;
				stats.rowMax <= nextMax;
				stats.tileCount <= nextCount;
				tileCount <= '0;   // fresh row
				runMin <= '1;
				runMax <= '0;
				rowSum <= '0;
				if (scores.endOfHead)
				begin
					headValid <= 1'b1;
					pruneHead <= (nextHeadSum <= headThreshold);
					headSum <= '0;
				end
				else
					headSum <= nextHeadSum;
			end
			else if (scores.valid)
			begin
				tileCount <= nextCount;
				runMin <= nextMin;
				runMax <= nextMax;
				rowSum <= nextRowSum;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rowStatsBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// finished row statistics, all fields valid while rowDone is high
interface rowStatsBus import attnPkg::*;
();

	logic rowDone;                                   // one cycle pulse
	logic [importanceWidth-1:0] rowMin;
	logic [importanceWidth-1:0] rowMax;
	logic [tileIndexWidth-1:0] tileCount;            // tiles stored this row
	logic [importanceWidth-1:0] scores [tilesPerRow];

	modport source (output rowDone, output rowMin, output rowMax, output tileCount,
		output scores);

	modport sink (input rowDone, input rowMin, input rowMax, input tileCount,
		input scores);

endinterface

`default_nettype wire

// ==== verilog/scoreBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// tile importance, execute stage to row scorer
interface scoreBus import attnPkg::*;
();

	logic valid;
	logic endOfRow;    // only meaningful with valid
	logic endOfHead;
	logic [importanceWidth-1:0] importance;

	modport source (output valid, output endOfRow, output endOfHead, output importance);

	modport sink (input valid, input endOfRow, input endOfHead, input importance);

endinterface

`default_nettype wire

// ==== verilog/tileBus.sv ====
`timescale 1ns/1ps
`default_nettype none

// decoded tile and its strobes, decode stage to execute stage
interface tileBus import attnPkg::*;
();

	logic valid;       // one cycle per tile
	logic endOfRow;
	logic endOfHead;

	logic signed [dataWidth-1:0] a [tileElems];   // (i,k) at i*tileDim+k
	logic signed [dataWidth-1:0] b [tileElems];   // (k,j) at k*tileDim+j

	modport source (output valid, output endOfRow, output endOfHead, output a, output b);

	modport sink (input valid, input endOfRow, input endOfHead, input a, input b);

endinterface

`default_nettype wire

// ==== verilog/tileDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tileDecode import attnPkg::*;
(
	input wire clk,
	input wire _resetRow,
	input wire tileValid,
	input wire endOfRow,
	input wire endOfHead,
	input wire [tileElems*dataWidth-1:0] aTile,
	input wire [tileElems*dataWidth-1:0] bTile,
	tileBus.source tiles
);

	// -------------------- strobes
	always_ff @(posedge clk or negedge _resetRow)
	begin
		if (!_resetRow)
		begin
			tiles.valid <= 1'b0;
			tiles.endOfRow <= 1'b0;
			tiles.endOfHead <= 1'b0;
		end
		else
		begin
			tiles.valid <= tileValid;
			tiles.endOfRow <= tileValid & endOfRow;     // row end only counts with a tile
			tiles.endOfHead <= tileValid & endOfHead;
		end
	end

	// -------------------- operands
	// element n sits at slice n*dataWidth of the flat word
	always_ff @(posedge clk)
	begin
		if (tileValid)
		begin
			for (int n = 0; n < tileElems; n++)
			begin
				tiles.a[n] <= aTile[n*dataWidth +: dataWidth];
				tiles.b[n] <= bTile[n*dataWidth +: dataWidth];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tileMultiply.sv ====
`timescale 1ns/1ps
`default_nettype none

module tileMultiply import attnPkg::*;
(
	input wire clk,
	input wire _resetRow,
	tileBus.sink tiles,
	scoreBus.source scores,
	output logic resultValid,
	output logic [tileElems*accWidth-1:0] result
);

	logic signed [accWidth-1:0] sums [tileElems];   // (i,j) at i*tileDim+j
	logic [importanceWidth-1:0] absSum;

	// -------------------- 4x4 product
	always_comb
	begin
		for (int i = 0; i < tileDim; i++)
		begin
			for (int j = 0; j < tileDim; j++)
			begin
				sums[i*tileDim+j] = '0;
				for (int k = 0; k < tileDim; k++)
					sums[i*tileDim+j] = sums[i*tileDim+j]
						+ tiles.a[i*tileDim+k] * tiles.b[k*tileDim+j];
			end
		end
	end

	// tile importance is the sum of magnitudes
	always_comb
	begin
		absSum = '0;
		for (int n = 0; n < tileElems; n++)
		begin
			if (sums[n][accWidth-1])
				absSum = absSum + importanceWidth'(-sums[n]);
			else
				absSum = absSum + importanceWidth'(sums[n]);
		end
	end

	// -------------------- output stage
	always_ff @(posedge clk or negedge _resetRow)
	begin
		if (!_resetRow)
		begin
			resultValid <= 1'b0;
			result <= '0;
			scores.valid <= 1'b0;
			scores.endOfRow <= 1'b0;
			scores.endOfHead <= 1'b0;
		end
		else
		begin
			resultValid <= tiles.valid;
			scores.valid <= tiles.valid;
			scores.endOfRow <= tiles.endOfRow;
			scores.endOfHead <= tiles.endOfHead;
			if (tiles.valid)   // result holds between tiles
			begin
				for (int n = 0; n < tileElems; n++)
					result[n*accWidth +: accWidth] <= sums[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (tiles.valid)
			scores.importance <= absSum;
	end

endmodule

`default_nettype wire
